// File: design/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width seen by the processor and memory
`define DCACHE_ADDR_W 32

// one data word
`define DCACHE_WORD_W 32

// tag covers address bits 31 down to 6
`define DCACHE_TAG_W 26

// set index covers address bits 5 down to 3
`define DCACHE_INDEX_W 3

// number of sets in each way
`define DCACHE_SETS 8

// flush walks all of way 0 and then all of way 1
`define DCACHE_FLUSH_SLOTS 16

`endif

// File: design/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

   typedef logic [`DCACHE_WORD_W-1:0] word_t;
   typedef logic [`DCACHE_TAG_W-1:0] tag_t;
   typedef logic [`DCACHE_INDEX_W-1:0] index_t;

   // byte address split into cache fields, msb first
   typedef struct packed {
      tag_t       tag;
      index_t     index;
      logic       wsel;
      logic [1:0] boff;
   } addr_fields_t;

   // one way's block as seen outside the storage
   typedef struct packed {
      tag_t  tag;
      word_t word0;
      word_t word1;
      logic  valid;
      logic  dirty;
   } block_t;

   // controller states
   // WB1/WB2 evict a dirty victim, READ1/READ2 refill
   // SCAN/FLUSH1/FLUSH2 walk the cache on halt
   typedef enum logic [3:0] {
      IDLE, WB1, WB2, READ1, READ2, SCAN, FLUSH1, FLUSH2, HALT
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/dcache_bus_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_bus_pkg;

   // processor request, held as levels until hit
   typedef struct packed {
      logic                     ren;
      logic                     wen;
      logic [`DCACHE_ADDR_W-1:0] addr;
      logic [`DCACHE_WORD_W-1:0] store;
   } cpu_req_t;

   // hit strobe with read data
   typedef struct packed {
      logic                     hit;
      logic [`DCACHE_WORD_W-1:0] load;
   } cpu_rsp_t;

   // memory request, held until wait drops
   typedef struct packed {
      logic                     ren;
      logic                     wen;
      logic [`DCACHE_ADDR_W-1:0] addr;
      logic [`DCACHE_WORD_W-1:0] store;
   } mem_req_t;

endpackage

`default_nettype wire

// File: design/dcache_array.sv
`default_nettype none
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_array
   import dcache_pkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   // lookup for the pending processor request
   input  index_t     lookup_index,
   input  tag_t       lookup_tag,
   // flush slot, top bit picks the way
   input  logic [3:0] scan_slot,
   // single block write port
   input  logic       wr_en,
   input  logic       wr_way,
   input  index_t     wr_index,
   input  block_t     wr_block,
   // replacement bit update
   input  logic       lru_en,
   input  index_t     lru_index,
   input  logic       lru_next,
   output logic       hit,
   output logic       hit_way,
   output block_t     hit_block,
   output logic       victim_way,
   output block_t     victim_block,
   output block_t     scan_block
);

   // tag and data storage, two ways of eight sets
   tag_t  tag_mem   [2][`DCACHE_SETS];
   word_t word0_mem [2][`DCACHE_SETS];
   word_t word1_mem [2][`DCACHE_SETS];

   // valid and dirty flags per way, one bit per set
   logic [`DCACHE_SETS-1:0] valid_q [2];
   logic [`DCACHE_SETS-1:0] dirty_q [2];

   // way to replace next, one bit per set
   logic [`DCACHE_SETS-1:0] lru_q;

   logic way0_match;
   logic way1_match;

   // gather one way's entry into a block
   function automatic block_t read_block(input logic way, input index_t index);
      block_t blk;
      blk.tag   = tag_mem[way][index];
      blk.word0 = word0_mem[way][index];
      blk.word1 = word1_mem[way][index];
      blk.valid = valid_q[way][index];
      blk.dirty = dirty_q[way][index];
      return blk;
   endfunction

   // tag and data writes
   always_ff @(posedge CLK)
   begin
      if (wr_en)
      begin
         tag_mem[wr_way][wr_index]   <= wr_block.tag;
         word0_mem[wr_way][wr_index] <= wr_block.word0;
         word1_mem[wr_way][wr_index] <= wr_block.word1;
      end
   end

   // valid, dirty and replacement bits
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '{default: '0};
         dirty_q <= '{default: '0};
         lru_q   <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            valid_q[wr_way][wr_index] <= wr_block.valid;
            dirty_q[wr_way][wr_index] <= wr_block.dirty;
         end
         // hit or refill points the set at the other way
         if (lru_en)
            lru_q[lru_index] <= lru_next;
      end
   end

   // lookups are purely combinational
   always_comb
   begin
      // a way matches only with a valid tag
      way0_match = valid_q[0][lookup_index] && (tag_mem[0][lookup_index] == lookup_tag);
      way1_match = valid_q[1][lookup_index] && (tag_mem[1][lookup_index] == lookup_tag);
      hit        = way0_match | way1_match;
      // way 1 only when it alone matches
      hit_way    = way1_match & ~way0_match;
      hit_block  = read_block(hit_way, lookup_index);

      // victim follows the replacement bit
      victim_way   = lru_q[lookup_index];
      victim_block = read_block(victim_way, lookup_index);

      // flush slot 0..7 is way 0, 8..15 is way 1
      scan_block = read_block(scan_slot[`DCACHE_INDEX_W],
                              scan_slot[`DCACHE_INDEX_W-1:0]);
   end

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_ctrl
   import dcache_pkg::*;
   import dcache_bus_pkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   // processor side
   input  cpu_req_t   cpu_req,
   input  logic       halt,
   // memory side
   input  word_t      mem_load,
   input  logic       mem_wait,
   // lookup results from the array
   input  logic       hit,
   input  logic       hit_way,
   input  block_t     hit_block,
   input  logic       victim_way,
   input  block_t     victim_block,
   input  block_t     scan_block,
   output cpu_rsp_t   cpu_rsp,
   output logic       flushed,
   output mem_req_t   mem_req,
   // array control
   output index_t     lookup_index,
   output tag_t       lookup_tag,
   output logic [3:0] scan_slot,
   output logic       wr_en,
   output logic       wr_way,
   output index_t     wr_index,
   output block_t     wr_block,
   output logic       lru_en,
   output index_t     lru_index,
   output logic       lru_next
);

   // one extra bit marks the end of the walk
   localparam int SLOT_CNT_W = $clog2(`DCACHE_FLUSH_SLOTS) + 1;

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   logic [SLOT_CNT_W-1:0] slot_q;
   logic [SLOT_CNT_W-1:0] slot_d;

   // first refill word, held until the second arrives
   word_t refill_w0_q;

   addr_fields_t req_f;
   logic         req_any;
   logic         word_done;
   logic         scan_dirty;

   // memory address of one word of a block
   function automatic logic [`DCACHE_ADDR_W-1:0] block_addr(
      input tag_t   tag,
      input index_t index,
      input logic   wsel
   );
      addr_fields_t f;
      f.tag   = tag;
      f.index = index;
      f.wsel  = wsel;
      f.boff  = 2'b00;
      return f;
   endfunction

   assign req_f        = cpu_req.addr;
   assign lookup_index = req_f.index;
   assign lookup_tag   = req_f.tag;
   assign req_any      = cpu_req.ren | cpu_req.wen;
   // a word moves once wait is low
   assign word_done    = ~mem_wait;
   assign scan_slot    = slot_q[3:0];
   assign scan_dirty   = scan_block.valid & scan_block.dirty;
   // level stays up until reset
   assign flushed      = (state_q == HALT);

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state_q <= IDLE;
         slot_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         slot_q  <= slot_d;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (state_q == READ1 && word_done)
         refill_w0_q <= mem_load;
   end

   always_comb
   begin
      state_d = state_q;
      slot_d  = slot_q;

      // read data always follows the hit block
      cpu_rsp.hit  = 1'b0;
      cpu_rsp.load = req_f.wsel ? hit_block.word1 : hit_block.word0;

      mem_req = '0;

      // write port defaults to the hitting block
      wr_en    = 1'b0;
      wr_way   = hit_way;
      wr_index = lookup_index;
      wr_block = hit_block;

      lru_en    = 1'b0;
      lru_index = lookup_index;
      lru_next  = ~hit_way;

      case (state_q)
         IDLE:
         begin
            // halt wins over any pending request
            if (halt)
            begin
               slot_d  = '0;
               state_d = SCAN;
            end
            else if (req_any && hit)
            begin
               cpu_rsp.hit = 1'b1;
               lru_en      = 1'b1;
               // write hit merges the store word and marks dirty
               if (cpu_req.wen)
               begin
                  wr_en          = 1'b1;
                  wr_block.dirty = 1'b1;
                  if (req_f.wsel)
                     wr_block.word1 = cpu_req.store;
                  else
                     wr_block.word0 = cpu_req.store;
               end
            end
            else if (req_any)
            begin
               // dirty victim goes back to memory first
               if (victim_block.valid && victim_block.dirty)
                  state_d = WB1;
               else
                  state_d = READ1;
            end
         end
         WB1:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(victim_block.tag, lookup_index, 1'b0);
            mem_req.store = victim_block.word0;
            if (word_done)
               state_d = WB2;
         end
         WB2:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(victim_block.tag, lookup_index, 1'b1);
            mem_req.store = victim_block.word1;
            if (word_done)
               state_d = READ1;
         end
         READ1:
         begin
            mem_req.ren  = 1'b1;
            mem_req.addr = block_addr(lookup_tag, lookup_index, 1'b0);
            if (word_done)
               state_d = READ2;
         end
         READ2:
         begin
            mem_req.ren  = 1'b1;
            mem_req.addr = block_addr(lookup_tag, lookup_index, 1'b1);
            if (word_done)
            begin
               // install the whole block over the victim
               wr_en          = 1'b1;
               wr_way         = victim_way;
               wr_block.tag   = lookup_tag;
               wr_block.word0 = refill_w0_q;
               wr_block.word1 = mem_load;
               wr_block.valid = 1'b1;
               // dirty already when the held request is a store
               wr_block.dirty = cpu_req.wen;
               lru_en         = 1'b1;
               lru_next       = ~victim_way;
               // request then hits back in IDLE
               state_d        = IDLE;
            end
         end
         SCAN:
         begin
            // one slot per cycle
            if (slot_q == SLOT_CNT_W'(`DCACHE_FLUSH_SLOTS))
               state_d = HALT;
            else if (scan_dirty)
               state_d = FLUSH1;
            else
               slot_d = slot_q + 1'b1;
         end
         FLUSH1:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(scan_block.tag, slot_q[`DCACHE_INDEX_W-1:0], 1'b0);
            mem_req.store = scan_block.word0;
            if (word_done)
               state_d = FLUSH2;
         end
         FLUSH2:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(scan_block.tag, slot_q[`DCACHE_INDEX_W-1:0], 1'b1);
            mem_req.store = scan_block.word1;
            if (word_done)
            begin
               // block is clean once both words are out
               wr_en          = 1'b1;
               wr_way         = slot_q[`DCACHE_INDEX_W];
               wr_index       = slot_q[`DCACHE_INDEX_W-1:0];
               wr_block       = scan_block;
               wr_block.dirty = 1'b0;
               slot_d         = slot_q + 1'b1;
               state_d        = SCAN;
            end
         end
         HALT:
         begin
            // parked until reset
            state_d = HALT;
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
   import dcache_bus_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   // processor side
   input  cpu_req_t cpu_req,
   input  logic     halt,
   output cpu_rsp_t cpu_rsp,
   output logic     flushed,
   // memory side
   input  word_t    mem_load,
   input  logic     mem_wait,
   output mem_req_t mem_req
);

   // lookup path
   index_t     lookup_index;
   tag_t       lookup_tag;
   logic       hit;
   logic       hit_way;
   block_t     hit_block;
   logic       victim_way;
   block_t     victim_block;

   // flush walk
   logic [3:0] scan_slot;
   block_t     scan_block;

   // array updates
   logic       wr_en;
   logic       wr_way;
   index_t     wr_index;
   block_t     wr_block;
   logic       lru_en;
   index_t     lru_index;
   logic       lru_next;

   // port names match the nets above
   dcache_ctrl u_ctrl (.*);

   dcache_array u_array (.*);

endmodule

`default_nettype wire

// File: sim/dcache_sva.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_sva
   import dcache_bus_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input cpu_rsp_t cpu_rsp,
   input logic     flushed,
   input logic     mem_wait,
   input mem_req_t mem_req
);

   // one direction per memory transfer
   a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_req.ren && mem_req.wen))
      else $error("memory read and write requested together");

   // request frozen while memory stalls
   a_held: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_req.ren || mem_req.wen) && mem_wait |=> $stable(mem_req))
      else $error("memory request changed while mem_wait was high");

   // flushed is a level that only reset clears
   a_flushed: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
      else $error("flushed dropped after it was raised");

   // hits only come from IDLE, never during a transfer
   a_hit_idle: assert property (@(posedge CLK) disable iff (!nRST)
      cpu_rsp.hit |-> !(mem_req.ren || mem_req.wen))
      else $error("hit raised during a memory transfer");

endmodule

// attached to every instance of the top level
bind dcache_top dcache_sva i_sva (.*);

`default_nettype wire

// File: sim/dcache_tb.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_tb
   import dcache_pkg::*;
   import dcache_bus_pkg::*;
();

   localparam int MEM_WORDS     = 1024;
   localparam int HIT_TIMEOUT   = 64;
   localparam int FLUSH_TIMEOUT = 256;
   // preload pattern, each word is its byte address xor this
   localparam logic [31:0] MEM_XOR = 32'h5e1f0000;

   logic     CLK;
   logic     nRST;
   cpu_req_t cpu_req;
   logic     halt;
   cpu_rsp_t cpu_rsp;
   logic     flushed;
   word_t    mem_load;
   logic     mem_wait = 1'b0;
   mem_req_t mem_req;

   // memory model state, 4 KB of words
   word_t       mem [MEM_WORDS];
   logic [1:0]  wait_left = 2'd0;
   int unsigned delay;

   int test_errors  = 0;
   int total_errors = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   dcache_top i_dut (
      .CLK      (CLK),
      .nRST     (nRST),
      .cpu_req  (cpu_req),
      .halt     (halt),
      .cpu_rsp  (cpu_rsp),
      .flushed  (flushed),
      .mem_load (mem_load),
      .mem_wait (mem_wait),
      .mem_req  (mem_req)
   );

   initial
   begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // read data follows the held address
   assign mem_load = mem[mem_req.addr[11:2]];

   // seed once, fill every word from its own address, then serve transfers
   initial
   begin
      void'($urandom(32'h26b6a881));
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] <= (32'(i) << 2) ^ MEM_XOR;
      forever
      begin
         @(posedge CLK);
         if (mem_req.ren || mem_req.wen)
         begin
            if (!mem_wait)
            begin
               // word moves at this edge
               if (mem_req.wen)
                  mem[mem_req.addr[11:2]] <= mem_req.store;
               // 0 to 3 wait cycles before the next word
               delay = $urandom_range(3, 0);
               wait_left <= 2'(delay);
               mem_wait  <= (delay != 0);
            end
            else
            begin
               if (wait_left <= 2'd1)
                  mem_wait <= 1'b0;
               wait_left <= wait_left - 2'd1;
            end
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("[FAIL] %0t: %s expected %h, got %h", $time, name, expected, actual);
         test_errors++;
      end
   endtask

   // bit 0 is a memory read, bit 1 a memory write
   task automatic compare_traffic(input logic [1:0] expected, input logic [1:0] seen);
      check_value("mem_req.ren", 32'(expected[0]), 32'(seen[0]));
      check_value("mem_req.wen", 32'(expected[1]), 32'(seen[1]));
   endtask

   // hold one request until hit, noting memory traffic on the way
   task automatic cache_access(input logic is_write, input logic [31:0] addr,
                               input logic [31:0] store, output logic [31:0] load,
                               output logic [1:0] traffic);
      int   cycles;
      logic done;
      traffic = 2'b00;
      load    = '0;
      done    = 1'b0;
      cycles  = 0;
      @(posedge CLK);
      cpu_req.ren   <= ~is_write;
      cpu_req.wen   <= is_write;
      cpu_req.addr  <= addr;
      cpu_req.store <= store;
      while (!done && cycles < HIT_TIMEOUT)
      begin
         // outputs settled by the falling edge
         @(negedge CLK);
         traffic[0] = traffic[0] | mem_req.ren;
         traffic[1] = traffic[1] | mem_req.wen;
         if (cpu_rsp.hit)
         begin
            done = 1'b1;
            load = cpu_rsp.load;
         end
         cycles++;
      end
      assert (done)
      else
      begin
         $display("timeout: no hit for address %h after %0d cycles", addr, HIT_TIMEOUT);
         test_errors++;
      end
      @(posedge CLK);
      cpu_req <= '0;
   endtask

   task automatic wait_flushed();
      int   cycles;
      logic done;
      done   = 1'b0;
      cycles = 0;
      @(posedge CLK);
      halt <= 1'b1;
      while (!done && cycles < FLUSH_TIMEOUT)
      begin
         @(negedge CLK);
         done = flushed;
         cycles++;
      end
      assert (done)
      else
      begin
         $display("timeout: flushed not raised after %0d cycles of halt", FLUSH_TIMEOUT);
         test_errors++;
      end
      // parked, no more memory traffic
      repeat (4)
      begin
         @(negedge CLK);
         check_value("flushed", 32'd1, 32'(flushed));
         compare_traffic(2'b00, {mem_req.wen, mem_req.ren});
      end
   endtask

   task automatic close_test(input int num);
      tests_run++;
      if (test_errors == 0)
         $display("test %0d: passed", num);
      else
      begin
         $display("test %0d: %0d errors", num, test_errors);
         tests_failed++;
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   initial
   begin
      int          fd;
      int          got;
      int          num;
      int          cur_test;
      string       line;
      string       op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] expected;
      logic [31:0] load;
      logic [1:0]  traffic;
      cpu_req = '0;
      halt    = 1'b0;
      nRST    = 1'b0;
      repeat (3) @(posedge CLK);
      nRST <= 1'b1;
      // test 0 covers the idle state straight after reset
      @(negedge CLK);
      check_value("cpu_rsp.hit", 32'd0, 32'(cpu_rsp.hit));
      compare_traffic(2'b00, {mem_req.wen, mem_req.ren});
      check_value("flushed", 32'd0, 32'(flushed));
      close_test(0);
      fd = $fopen("sim/dcache_tests.txt", "r");
      if (fd == 0)
      begin
         $display("could not open sim/dcache_tests.txt");
         total_errors++;
      end
      else
      begin
         cur_test = -1;
         while (!$feof(fd))
         begin
            line = "";
            got  = $fgets(line, fd);
            // comment and blank lines give fewer than five fields
            got = $sscanf(line, "%d %s %h %h %h", num, op, addr, data, expected);
            if (got == 5)
            begin
               if (num != cur_test)
               begin
                  if (cur_test >= 0)
                     close_test(cur_test);
                  cur_test = num;
               end
               if (op == "R")
               begin
                  cache_access(1'b0, addr, '0, load, traffic);
                  check_value("cpu_rsp.load", expected, load);
                  compare_traffic(data[1:0], traffic);
               end
               else if (op == "W")
               begin
                  cache_access(1'b1, addr, data, load, traffic);
                  compare_traffic(expected[1:0], traffic);
               end
               else if (op == "H")
                  wait_flushed();
               else if (op == "M")
                  check_value($sformatf("mem[%h]", addr), expected, mem[addr[11:2]]);
               else
               begin
                  $display("unknown operation %s in test %0d", op, num);
                  test_errors++;
               end
            end
         end
         if (cur_test >= 0)
            close_test(cur_test);
         $fclose(fd);
      end
      $display("summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, total_errors);
      if (total_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/dcache_tests.txt
# columns: test op addr data expect, all hex except test
# R: data = memory traffic seen (bit0 ren, bit1 wen), expect = load value
# W: data = store word, expect = memory traffic seen
# H: halt until flushed; M: expect = memory word at addr
1 R 00000008 00000001 5e1f0008
1 R 0000000c 00000000 5e1f000c
# write hit on a clean block, then read back
2 W 0000000c 11110001 00000000
2 R 0000000c 00000000 11110001
2 R 00000008 00000000 5e1f0008
# three tags in set 1, first tag re-read in between
3 R 00000048 00000001 5e1f0048
3 R 00000008 00000000 5e1f0008
3 R 00000088 00000001 5e1f0088
3 R 00000008 00000000 5e1f0008
3 R 00000048 00000001 5e1f0048
# dirty victims go back to memory before the refill
4 R 000000c8 00000003 5e1f00c8
4 M 0000000c 00000000 11110001
4 M 00000008 00000000 5e1f0008
4 W 00000010 22220010 00000001
4 W 00000054 22220054 00000001
4 W 00000090 22220090 00000003
4 M 00000010 00000000 22220010
4 M 00000014 00000000 5e1f0014
4 M 00000054 00000000 5e1f0054
# halt flushes the two dirty blocks of set 2
5 H 00000000 00000000 00000000
5 M 0000000c 00000000 11110001
5 M 00000010 00000000 22220010
5 M 00000054 00000000 22220054
5 M 00000090 00000000 22220090
5 M 00000050 00000000 5e1f0050
5 M 00000094 00000000 5e1f0094

// File: list.f
+incdir+design
design/dcache_pkg.sv
design/dcache_bus_pkg.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/dcache_sva.sv
sim/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # packages ahead of the modules that import them
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/dcache_bus_pkg.sv
      - design/dcache_array.sv
      - design/dcache_ctrl.sv
      - design/dcache_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/dcache_sva.sv
      - sim/dcache_tb.sv
